// File: sim.f
hdl/decode_pkg.sv
hdl/fetch_buffer.sv
hdl/instr_decoder.sv
hdl/decode_stage.sv
hdl/register_read.sv
hdl/decode_top.sv
test/decode_sva.sv
test/decode_tb.sv

// File: run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module decode_tb -o decode_sim > sim.log 2>&1 \
  && ./obj_dir/decode_sim >> sim.log 2>&1 \
  || echo "RESULT: FAIL" >> sim.log

cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

// File: test/decode_tb.sv
`timescale 1ns/1ps

module decode_tb import decode_pkg::*; ();

  localparam int reset_cycles   = 2;
  localparam int preload_cycles = 31;
  localparam int test_cycles    = 40;  // each directed test needs only a few cycles
  localparam int cycle_limit    = 2 * (reset_cycles + preload_cycles + test_cycles);
  localparam logic [31:0] seed  = 32'h0e40_789c;

  logic        clock = 1'b0;
  logic        reset;
  fetch_pair_t fetch;
  logic        hold;
  logic        clear;
  load_fb_t    load_fb;
  wb_t         wb;
  logic        stall;
  issue_t      issue;

  logic [31:0] model [32];  // expected register file contents
  logic [31:0] rng_state;
  int          cycle_count = 0;

  decode_top #(.reg_count(32)) uut (
    .clock(clock), .reset(reset), .fetch(fetch), .hold(hold), .clear(clear),
    .load_fb(load_fb), .wb(wb), .stall(stall), .issue(issue)
  );

  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is %h, expected %h", name, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // returns on the falling edge after the buffer took the pair
  task automatic present_pair(input logic [31:0] pc, input logic [31:0] i0,
                              input logic [31:0] i1);
    while (stall == 1) @(negedge clock);
    fetch.pc     = pc;
    fetch.instr0 = i0;
    fetch.instr1 = i1;
    fetch.valid  = 1'b1;
    @(negedge clock);
    fetch.valid  = 1'b0;
  endtask

  task automatic test_reset();
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    check("issue.slot0.valid", 32'(issue.slot0.valid), 32'd0);
    check("issue.slot1.valid", 32'(issue.slot1.valid), 32'd0);
    check("stall", 32'(stall), 32'd0);
  endtask

  task automatic preload_registers();
    model[0] = 32'd0;
    for (int r = 1; r < 32; r++) begin
      rng_state = lcg_next(rng_state);
      model[r]  = rng_state;
      wb.wen    = 1'b1;
      wb.waddr  = 5'(r);
      wb.wdata  = rng_state;
      @(negedge clock);
    end
    wb.wen = 1'b0;
  endtask

  task automatic test_dual_issue();
    logic [31:0] sub_word;
    logic [31:0] addi_word;
    sub_word  = r_type(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd5, opc_op);  // sub x5, x1, x2
    addi_word = i_type(12'hffb, 5'd3, 3'b000, 5'd6, opc_op_imm);       // addi x6, x3, -5
    present_pair(32'h0000_1000, sub_word, addi_word);
    check("stall", 32'(stall), 32'd0);
    @(negedge clock);
    check("issue.slot0.valid", 32'(issue.slot0.valid), 32'd1);
    check("issue.slot1.valid", 32'(issue.slot1.valid), 32'd1);
    check("issue.slot0.dec.pc", issue.slot0.dec.pc, 32'h0000_1000);
    check("issue.slot1.dec.pc", issue.slot1.dec.pc, 32'h0000_1004);
    check("issue.slot1.dec.imm", issue.slot1.dec.imm, 32'hffff_fffb);
    check("issue.slot0.dec.alu_op", 32'(issue.slot0.dec.alu_op), 32'(alu_sub));
    check("issue.slot1.dec.alu_op", 32'(issue.slot1.dec.alu_op), 32'(alu_add));
    check("issue.slot0.rdata1", issue.slot0.rdata1, model[1]);
    check("issue.slot0.rdata2", issue.slot0.rdata2, model[2]);
    check("issue.slot1.rdata1", issue.slot1.rdata1, model[3]);
  endtask

  task automatic test_split(input logic [31:0] pc, input logic [31:0] i0,
                            input logic [31:0] i1);
    present_pair(pc, i0, i1);
    check("stall", 32'(stall), 32'd1);
    @(negedge clock);
    check("issue.slot0.valid", 32'(issue.slot0.valid), 32'd1);
    check("issue.slot1.valid", 32'(issue.slot1.valid), 32'd0);
    check("issue.slot0.dec.pc", issue.slot0.dec.pc, pc);
    check("stall", 32'(stall), 32'd0);
    @(negedge clock);
    check("issue.slot0.valid", 32'(issue.slot0.valid), 32'd1);
    check("issue.slot1.valid", 32'(issue.slot1.valid), 32'd0);
    check("issue.slot0.dec.pc", issue.slot0.dec.pc, pc + 32'd4);
    check("issue.slot0.dec.waddr", 32'(issue.slot0.dec.waddr), 32'(i1[11:7]));
    check("issue.slot0.rdata1", issue.slot0.rdata1, model[i1[19:15]]);
  endtask

  task automatic test_load_use();
    logic [31:0] add_word;
    logic [31:0] addi_word;
    add_word  = r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd11, opc_op);  // add x11, x1, x2
    addi_word = i_type(12'd7, 5'd3, 3'b000, 5'd12, opc_op_imm);
    load_fb.busy  = 1'b1;
    load_fb.waddr = 5'd1;
    present_pair(32'h0000_3000, add_word, addi_word);
    check("stall", 32'(stall), 32'd1);
    repeat (3) begin
      @(negedge clock);
      check("issue.slot0.valid", 32'(issue.slot0.valid), 32'd0);
      check("issue.slot1.valid", 32'(issue.slot1.valid), 32'd0);
      check("stall", 32'(stall), 32'd1);
    end
    load_fb.busy = 1'b0;
    #1;
    check("stall", 32'(stall), 32'd0);
    @(negedge clock);
    check("issue.slot0.valid", 32'(issue.slot0.valid), 32'd1);
    check("issue.slot1.valid", 32'(issue.slot1.valid), 32'd1);
    check("issue.slot0.dec.pc", issue.slot0.dec.pc, 32'h0000_3000);
    check("issue.slot0.rdata1", issue.slot0.rdata1, model[1]);
    check("issue.slot1.dec.imm", issue.slot1.dec.imm, 32'd7);
  endtask

  task automatic test_exception(input logic [31:0] word, input logic [3:0] cause);
    logic [31:0] addi_word;
    addi_word = i_type(12'd1, 5'd1, 3'b000, 5'd1, opc_op_imm);
    present_pair(32'h0000_5000, word, addi_word);
    check("stall", 32'(stall), 32'd1);  // trapping slot 0 goes alone
    @(negedge clock);
    check("issue.slot0.valid", 32'(issue.slot0.valid), 32'd1);
    check("issue.slot0.exception", 32'(issue.slot0.exception), 32'd1);
    check("issue.slot0.ecause", 32'(issue.slot0.ecause), 32'(cause));
    check("issue.slot0.etval", issue.slot0.etval, word);
    check("issue.slot1.valid", 32'(issue.slot1.valid), 32'd0);
    @(negedge clock);
    check("issue.slot0.exception", 32'(issue.slot0.exception), 32'd0);
    check("issue.slot0.dec.pc", issue.slot0.dec.pc, 32'h0000_5004);
  endtask

  task automatic test_clear();
    logic [31:0] add_word;
    logic [31:0] addi_word;
    add_word  = r_type(7'b0000000, 5'd5, 5'd4, 3'b000, 5'd13, opc_op);
    addi_word = i_type(12'd1, 5'd6, 3'b000, 5'd14, opc_op_imm);
    present_pair(32'h0000_4000, add_word, addi_word);
    clear       = 1'b1;
    fetch.valid = 1'b1;  // a pair arriving with the flush is dropped as well
    @(negedge clock);
    clear       = 1'b0;
    fetch.valid = 1'b0;
    check("issue.slot0.valid", 32'(issue.slot0.valid), 32'd0);
    check("issue.slot1.valid", 32'(issue.slot1.valid), 32'd0);
    @(negedge clock);
    check("issue.slot0.valid", 32'(issue.slot0.valid), 32'd0);
    check("stall", 32'(stall), 32'd0);
  endtask

  task automatic test_bypass();
    logic [31:0] add_word;
    logic [31:0] addi_word;
    add_word  = r_type(7'b0000000, 5'd17, 5'd16, 3'b000, 5'd15, opc_op);
    addi_word = i_type(12'd3, 5'd19, 3'b000, 5'd18, opc_op_imm);
    present_pair(32'h0000_6000, add_word, addi_word);
    rng_state = lcg_next(rng_state);
    model[16] = rng_state;
    wb.wen    = 1'b1;  // lands in the same cycle as the read
    wb.waddr  = 5'd16;
    wb.wdata  = rng_state;
    @(negedge clock);
    wb.wen = 1'b0;
    check("issue.slot0.rdata1", issue.slot0.rdata1, model[16]);
    check("issue.slot0.rdata2", issue.slot0.rdata2, model[17]);
    check("issue.slot1.rdata1", issue.slot1.rdata1, model[19]);
    check("issue.slot1.valid", 32'(issue.slot1.valid), 32'd1);
  endtask

  initial begin
    reset     = 1'b0;
    fetch     = '0;
    hold      = 1'b0;
    clear     = 1'b0;
    load_fb   = '0;
    wb        = '0;
    rng_state = seed;
    test_reset();
    preload_registers();
    test_dual_issue();
    test_split(32'h0000_2000, i_type(12'd16, 5'd1, 3'b000, 5'd7, opc_op_imm),
               r_type(7'b0000000, 5'd2, 5'd7, 3'b000, 5'd8, opc_op));
    test_split(32'h0000_2100, i_type(12'd1, 5'd0, 3'b000, 5'd9, opc_op_imm),
               i_type(12'd4, 5'd1, 3'b010, 5'd10, opc_load));  // lw is not slot 1 material
    test_load_use();
    test_exception(32'h0000_000b, 4'd2);
    test_exception(32'h0010_0073, 4'd3);
    test_exception(32'h0000_0073, 4'd11);
    test_clear();
    test_bypass();
    repeat (2) @(negedge clock);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: test/decode_sva.sv
`timescale 1ns/1ps

module decode_sva import decode_pkg::*; (
  input logic   clock,
  input logic   reset,
  input logic   clear,
  input issue_t issue
);

  // a lone slot 1 would break program order
  slot1_after_slot0: assert property (
    @(posedge clock) disable iff (reset == 0)
    issue.slot1.valid |-> issue.slot0.valid
  ) else $error("slot 1 issued while slot 0 was empty");

  clear_gives_bubble: assert property (
    @(posedge clock) disable iff (reset == 0)
    clear |=> (issue.slot0.valid == 0 && issue.slot1.valid == 0)
  ) else $error("a valid slot issued right after a flush");

  trap_issues_alone: assert property (
    @(posedge clock) disable iff (reset == 0)
    (issue.slot0.valid && issue.slot0.exception) |-> !issue.slot1.valid
  ) else $error("slot 1 issued beside a trapping slot 0");

endmodule

bind decode_top decode_sva sva (
  .clock(clock), .reset(reset), .clear(clear), .issue(issue)
);

// File: hdl/decode_top.sv
`timescale 1ns/1ps

module decode_top import decode_pkg::*; #(
  parameter int reg_count = 32
) (
  input  logic        clock,
  input  logic        reset,
  input  fetch_pair_t fetch,
  input  logic        hold,
  input  logic        clear,
  input  load_fb_t    load_fb,
  input  wb_t         wb,
  output logic        stall,
  output issue_t      issue
);

  fetch_pair_t cur;
  logic        shifted;
  logic        advance;
  logic        split;
  instr_word_t instr0;
  instr_word_t instr1;
  decoded_t    dec0;
  decoded_t    dec1;
  issue_t      next;

  fetch_buffer buffer (
    .clock(clock), .reset(reset), .fetch(fetch), .advance(advance),
    .split(split), .clear(clear), .cur(cur), .shifted(shifted)
  );

  instr_decoder #(.reg_count(reg_count)) decoder0 (.instr(instr0), .dec(dec0));
  instr_decoder #(.reg_count(reg_count)) decoder1 (.instr(instr1), .dec(dec1));

  decode_stage stage (
    .cur(cur), .shifted(shifted), .dec0(dec0), .dec1(dec1),
    .instr0(instr0), .instr1(instr1), .hold(hold), .clear(clear),
    .load_fb(load_fb), .next(next), .advance(advance), .split(split),
    .stall(stall)
  );

  register_read #(.reg_count(reg_count)) regread (
    .clock(clock), .reset(reset), .wb(wb), .next(next),
    .clear(clear), .issue(issue)
  );

endmodule

// File: hdl/register_read.sv
`timescale 1ns/1ps

module register_read import decode_pkg::*; #(
  parameter int reg_count = 32
) (
  input  logic   clock,
  input  logic   reset,
  input  wb_t    wb,
  input  issue_t next,
  input  logic   clear,
  output issue_t issue
);

  logic [31:0] regs [reg_count];
  logic [4:0]  raddr [4];
  logic [31:0] rdata [4];
  issue_t      filled;

  always_ff @(posedge clock) begin
    if (wb.wen == 1 && wb.waddr != 5'd0 && wb.waddr < reg_count) begin
      regs[wb.waddr] <= wb.wdata;
    end
  end

  assign raddr[0] = next.slot0.dec.raddr1;
  assign raddr[1] = next.slot0.dec.raddr2;
  assign raddr[2] = next.slot1.dec.raddr1;
  assign raddr[3] = next.slot1.dec.raddr2;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (raddr[i] == 5'd0 || raddr[i] >= reg_count) begin
        rdata[i] = 32'd0; // x0, or beyond rv32e
      end else if (wb.wen == 1 && wb.waddr == raddr[i]) begin
        rdata[i] = wb.wdata; // write in flight this cycle
      end else begin
        rdata[i] = regs[raddr[i]];
      end
    end
  end

  always_comb begin
    filled = next;
    filled.slot0.rdata1 = rdata[0];
    filled.slot0.rdata2 = rdata[1];
    filled.slot1.rdata1 = rdata[2];
    filled.slot1.rdata2 = rdata[3];
  end

  always_ff @(posedge clock) begin
    issue <= filled;
    if (reset == 0 || clear == 1) begin
      issue.slot0.valid <= 1'b0;
      issue.slot1.valid <= 1'b0;
    end
  end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
  input  fetch_pair_t cur,
  input  logic        shifted,
  input  decoded_t    dec0,
  input  decoded_t    dec1,
  output instr_word_t instr0,
  output instr_word_t instr1,
  input  logic        hold,
  input  logic        clear,
  input  load_fb_t    load_fb,
  output issue_t      next,
  output logic        advance,
  output logic        split,
  output logic        stall
);

  logic slot1_present;
  logic exc0;
  logic ctrl0;
  logic raw_pair;
  logic pair_ok;
  logic load_use;
  logic bubble;

  function automatic logic reads_reg(decoded_t d, logic [4:0] addr);
    reads_reg = (addr != 5'd0) &&
                ((d.op.rden1 && d.raddr1 == addr) || (d.op.rden2 && d.raddr2 == addr));
  endfunction

  assign instr0 = cur.instr0;
  assign instr1 = cur.instr1;

  assign slot1_present = cur.valid && !shifted;
  assign exc0  = !dec0.op.legal || dec0.op.ebreak || dec0.op.ecall;
  assign ctrl0 = dec0.op.jal || dec0.op.jalr || dec0.op.branch || dec0.op.fence;

  // slot 1 may not consume what slot 0 produces in the same cycle
  assign raw_pair = dec0.op.wren && reads_reg(dec1, dec0.waddr);

  assign pair_ok = slot1_present && dec1.op.legal && dec1.simple &&
                   !ctrl0 && !exc0 && !raw_pair;

  assign load_use = load_fb.busy && cur.valid &&
                    (reads_reg(dec0, load_fb.waddr) ||
                     (pair_ok && reads_reg(dec1, load_fb.waddr)));

  assign bubble  = load_use || hold || clear;
  assign split   = slot1_present && !pair_ok && !bubble;
  assign advance = clear || !(load_use || hold || split); // flush drops the fetched pair
  assign stall   = !advance;

  always_comb begin
    next = '0;

    next.slot0.dec    = dec0;
    next.slot0.dec.pc = cur.pc;
    next.slot0.valid  = cur.valid;
    if (cur.valid == 1) begin
      if (dec0.op.legal == 0) begin
        next.slot0.exception = 1'b1;
        next.slot0.ecause    = except_illegal_instruction;
        next.slot0.etval     = cur.instr0;
      end else if (dec0.op.ebreak == 1) begin
        next.slot0.exception = 1'b1;
        next.slot0.ecause    = except_breakpoint;
        next.slot0.etval     = cur.instr0;
      end else if (dec0.op.ecall == 1) begin
        next.slot0.exception = 1'b1;
        next.slot0.ecause    = except_env_call_mach;
        next.slot0.etval     = cur.instr0;
      end
    end

    next.slot1.dec    = dec1;
    next.slot1.dec.pc = cur.pc + 32'd4;
    next.slot1.valid  = pair_ok;

    if (bubble == 1) begin
      next.slot0.valid     = 1'b0;
      next.slot0.exception = 1'b0;
      next.slot1.valid     = 1'b0;
    end
  end

endmodule

// File: hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import decode_pkg::*; #(
  parameter int reg_count = 32
) (
  input  instr_word_t instr,
  output decoded_t    dec
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  function automatic alu_op_t alu_of(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  alu_of = alt ? alu_sub : alu_add;
      3'b001:  alu_of = alu_sll;
      3'b010:  alu_of = alu_slt;
      3'b011:  alu_of = alu_sltu;
      3'b100:  alu_of = alu_xor;
      3'b101:  alu_of = alt ? alu_sra : alu_srl;
      3'b110:  alu_of = alu_or;
      default: alu_of = alu_and;
    endcase
  endfunction

  assign opcode = instr.r_fmt.opcode;
  assign funct3 = instr.r_fmt.funct3;
  assign funct7 = instr.r_fmt.funct7;

  assign imm_i = {{20{instr.i_fmt.imm11_0[11]}}, instr.i_fmt.imm11_0};
  assign imm_s = {{20{instr.s_fmt.imm11_5[6]}}, instr.s_fmt.imm11_5, instr.s_fmt.imm4_0};
  assign imm_b = {{20{instr.b_fmt.imm12}}, instr.b_fmt.imm11, instr.b_fmt.imm10_5,
                  instr.b_fmt.imm4_1, 1'b0};
  assign imm_u = {instr.u_fmt.imm31_12, 12'd0};
  assign imm_j = {{12{instr.j_fmt.imm20}}, instr.j_fmt.imm19_12, instr.j_fmt.imm11,
                  instr.j_fmt.imm10_1, 1'b0};

  always_comb begin
    dec        = '0;
    dec.alu_op = alu_add;
    dec.waddr  = instr.r_fmt.rd;
    dec.raddr1 = instr.r_fmt.rs1;
    dec.raddr2 = instr.r_fmt.rs2;
    case (opcode)
      opc_lui: begin
        dec.op    = '{wren: 1'b1, lui: 1'b1, legal: 1'b1, default: 1'b0};
        dec.imm    = imm_u;
        dec.alu_op = alu_pass_b;
        dec.simple = 1'b1;
      end
      opc_auipc: begin
        dec.op    = '{wren: 1'b1, auipc: 1'b1, legal: 1'b1, default: 1'b0};
        dec.imm    = imm_u;
        dec.simple = 1'b1;
      end
      opc_jal: begin
        dec.op  = '{wren: 1'b1, jal: 1'b1, legal: 1'b1, default: 1'b0};
        dec.imm = imm_j;
      end
      opc_jalr: begin
        dec.op  = '{wren: 1'b1, rden1: 1'b1, jalr: 1'b1, default: 1'b0};
        dec.op.legal = (funct3 == 3'b000);
        dec.imm = imm_i;
      end
      opc_branch: begin
        dec.op  = '{rden1: 1'b1, rden2: 1'b1, branch: 1'b1, default: 1'b0};
        dec.op.legal = (funct3[2:1] != 2'b01); // 010 and 011 are reserved
        dec.imm = imm_b;
      end
      opc_load: begin
        dec.op  = '{wren: 1'b1, rden1: 1'b1, load: 1'b1, default: 1'b0};
        dec.op.legal = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
        dec.imm = imm_i;
      end
      opc_store: begin
        dec.op  = '{rden1: 1'b1, rden2: 1'b1, store: 1'b1, default: 1'b0};
        dec.op.legal = (funct3[2] == 1'b0) && (funct3 != 3'b011);
        dec.imm = imm_s;
      end
      opc_op_imm: begin
        dec.op     = '{wren: 1'b1, rden1: 1'b1, default: 1'b0};
        dec.imm    = imm_i;
        dec.simple = 1'b1;
        dec.alu_op = alu_of(funct3, (funct3 == 3'b101) && funct7[5]);
        if (funct3 == 3'b001) begin
          dec.op.legal = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          dec.op.legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          dec.op.legal = 1'b1;
        end
      end
      opc_op: begin
        dec.op     = '{wren: 1'b1, rden1: 1'b1, rden2: 1'b1, default: 1'b0};
        dec.simple = 1'b1;
        dec.alu_op = alu_of(funct3, funct7[5]);
        dec.op.legal = (funct7 == 7'b0000000) ||
                       (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      opc_misc_mem: begin
        dec.op = '{fence: 1'b1, default: 1'b0};
        dec.op.legal = (funct3 == 3'b000);
      end
      opc_system: begin
        dec.op.ecall  = (instr == 32'h0000_0073);
        dec.op.ebreak = (instr == 32'h0010_0073);
        dec.op.legal  = dec.op.ecall || dec.op.ebreak; // no csr support
      end
      default: begin
        dec.op.legal = 1'b0;
      end
    endcase
    // unused fields read as x0 so hazard compares stay quiet
    if (dec.op.wren == 0) dec.waddr = 5'd0;
    if (dec.op.rden1 == 0) dec.raddr1 = 5'd0;
    if (dec.op.rden2 == 0) dec.raddr2 = 5'd0;
    if (dec.waddr >= reg_count || dec.raddr1 >= reg_count || dec.raddr2 >= reg_count) begin
      dec.op.legal = 1'b0; // rv32e has only 16
    end
  end

endmodule

// File: hdl/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer import decode_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  fetch_pair_t fetch,
  input  logic        advance,
  input  logic        split,
  input  logic        clear,
  output fetch_pair_t cur,
  output logic        shifted
);

  logic        valid_q;
  logic [31:0] pc_q;
  instr_word_t instr0_q;
  instr_word_t instr1_q;

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      valid_q <= 1'b0;
      shifted <= 1'b0;
    end else if (clear == 1) begin
      valid_q <= 1'b0;
      shifted <= 1'b0; // drops a pending shift as well
    end else if (split == 1) begin
      shifted <= 1'b1;
    end else if (advance == 1) begin
      valid_q <= fetch.valid;
      shifted <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (split == 1) begin
      pc_q     <= pc_q + 32'd4;
      instr0_q <= instr1_q; // old slot 1 becomes slot 0
    end else if (advance == 1) begin
      pc_q     <= fetch.pc;
      instr0_q <= fetch.instr0;
      instr1_q <= fetch.instr1;
    end
  end

  always_comb begin
    cur.pc     = pc_q;
    cur.instr0 = instr0_q;
    cur.instr1 = instr1_q;
    cur.valid  = valid_q;
  end

endmodule

// File: hdl/decode_pkg.sv
package decode_pkg;

  localparam logic [6:0] opc_lui      = 7'b0110111;
  localparam logic [6:0] opc_auipc    = 7'b0010111;
  localparam logic [6:0] opc_jal      = 7'b1101111;
  localparam logic [6:0] opc_jalr     = 7'b1100111;
  localparam logic [6:0] opc_branch   = 7'b1100011;
  localparam logic [6:0] opc_load     = 7'b0000011;
  localparam logic [6:0] opc_store    = 7'b0100011;
  localparam logic [6:0] opc_op_imm   = 7'b0010011;
  localparam logic [6:0] opc_op       = 7'b0110011;
  localparam logic [6:0] opc_misc_mem = 7'b0001111;
  localparam logic [6:0] opc_system   = 7'b1110011;

  // mcause values for slot 0 traps
  localparam logic [3:0] except_illegal_instruction = 4'd2;
  localparam logic [3:0] except_breakpoint          = 4'd3;
  localparam logic [3:0] except_env_call_mach       = 4'd11;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, six ways to look at it
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_word_t;

  typedef struct packed {
    logic [31:0] pc;      // slot 1 sits at pc + 4
    instr_word_t instr0;
    instr_word_t instr1;
    logic        valid;
  } fetch_pair_t;

  typedef struct packed {
    logic wren;
    logic rden1;
    logic rden2;
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic fence;
    logic ecall;
    logic ebreak;
    logic legal;
  } op_flags_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] imm;
    logic [4:0]  waddr;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    op_flags_t   op;
    alu_op_t     alu_op;
    logic        simple;  // allowed in slot 1
  } decoded_t;

  typedef struct packed {
    decoded_t    dec;
    logic        valid;
    logic        exception;
    logic [3:0]  ecause;
    logic [31:0] etval;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
  } slot_t;

  typedef struct packed {
    slot_t slot0;
    slot_t slot1;
  } issue_t;

  typedef struct packed {
    logic        wen;
    logic [4:0]  waddr;
    logic [31:0] wdata;
  } wb_t;

  typedef struct packed {
    logic       busy;
    logic [4:0] waddr;
  } load_fb_t;

endpackage
